// ==== rtl/hdr_pkg.sv ====
// shared hdr-ddr types: path select, mode constant, preambles, word union, request structs
`default_nettype none

package hdr_pkg;

  // one select for every path mux in the datapath
  typedef enum logic {
    PATH_DDR = 1'b0,
    PATH_CCC = 1'b1
  } hdr_path_e;

  localparam logic [2:0] MODE_HDR_DDR = 3'd6;

  // ddr frame preambles
  localparam logic [1:0] PRE_CMD  = 2'b01;
  localparam logic [1:0] PRE_DATA = 2'b10;

  // command word fields, msb first on the bus
  typedef struct packed {
    logic       rnw;          // 1 = read
    logic [6:0] cmd_code;
    logic [6:0] target_addr;
    logic       rsvd;
  } hdr_cmd_s;

  // one 16-bit word seen as a command or as plain data
  typedef union packed {
    hdr_cmd_s    cmd;
    logic [15:0] data;
  } hdr_word_u;

  // sequencer to serializer, vld is a single-cycle strobe
  typedef struct packed {
    logic       vld;
    logic [1:0] preamble;
    hdr_word_u  word;
  } hdr_word_req_s;

  // sequencer to register file
  typedef struct packed {
    logic       en;
    logic [7:0] addr;
  } regf_rd_s;

endpackage

`default_nettype wire

// ==== rtl/hdr_engine.sv ====
// hdr engine with the control fsm choosing ccc or normal ddr transfers, restart, dummy word and exit
`timescale 1ns/1ps
`default_nettype none

module hdr_engine
  import hdr_pkg::*;
(
  input  logic       i_sys_clk,
  input  logic       i_sys_rst_n,
  input  logic       i_hdr_en,     // a new run starts on its rising edge
  input  logic       i_cp,         // command present (1 = ccc)
  input  logic       i_toc,        // term of completion (1 = exit)
  input  logic [2:0] i_mode,
  input  logic       i_ccc_done,
  input  logic       i_ddr_done,
  output logic       o_ccc_en,
  output logic       o_ccc_dummy,
  output logic       o_ddr_en,
  output hdr_path_e  o_path_sel,
  output logic       o_hdr_done
);

  typedef enum logic [1:0] {
    IDLE,
    CCC,
    CCC_DUMMY,
    DDR
  } state_e;

  state_e state;
  logic   hdr_en_q;
  logic   exit_now;     // taken when the current transfer finishes
  logic   mode_ok;

  assign mode_ok  = (i_mode == MODE_HDR_DDR);
  assign exit_now = i_toc || !mode_ok;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state       <= IDLE;
      hdr_en_q    <= 1'b0;
      o_ccc_en    <= 1'b0;
      o_ccc_dummy <= 1'b0;
      o_ddr_en    <= 1'b0;
      o_path_sel  <= PATH_DDR;
      o_hdr_done  <= 1'b0;
    end else begin
      hdr_en_q   <= i_hdr_en;
      o_hdr_done <= 1'b0;
      if (!i_hdr_en) begin
        // sequencers stop after the frame in flight
        state       <= IDLE;
        o_ccc_en    <= 1'b0;
        o_ccc_dummy <= 1'b0;
        o_ddr_en    <= 1'b0;
      end else begin
        case (state)
          IDLE: begin
            if (!hdr_en_q) begin
              state      <= i_cp ? CCC : DDR;
              o_path_sel <= i_cp ? PATH_CCC : PATH_DDR;
            end
          end
          CCC: begin
            if (i_ccc_done) begin
              o_ccc_en <= 1'b0;   // low for one cycle so a restart re-raises it
              if (exit_now) begin
                o_hdr_done <= 1'b1;
                state      <= IDLE;
              end else if (!i_cp) begin
                o_ccc_dummy <= 1'b1;
                state       <= CCC_DUMMY;
              end
            end else if (!o_ccc_en) begin
              o_ccc_en <= 1'b1;
            end
          end
          CCC_DUMMY: begin
            if (i_ccc_done) begin
              o_ccc_en    <= 1'b0;
              o_ccc_dummy <= 1'b0;
              if (!mode_ok) begin
                o_hdr_done <= 1'b1;
                state      <= IDLE;
              end else begin
                state      <= DDR;
                o_path_sel <= PATH_DDR;
              end
            end else if (!o_ccc_en) begin
              o_ccc_en <= 1'b1;
            end
          end
          DDR: begin
            if (i_ddr_done) begin
              o_ddr_en <= 1'b0;
              if (exit_now) begin
                o_hdr_done <= 1'b1;
                state      <= IDLE;
              end else if (i_cp) begin
                state      <= CCC;
                o_path_sel <= PATH_CCC;
              end
            end else if (!o_ddr_en) begin
              o_ddr_en <= 1'b1;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // only one sequencer may own the serializer
  a_one_path: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    !(o_ccc_en && o_ddr_en));

endmodule

`default_nettype wire

// ==== rtl/hdr_ccc_seq.sv ====
// ccc sequencer sending the command word then the data word, or the dummy word alone
`timescale 1ns/1ps
`default_nettype none

module hdr_ccc_seq
  import hdr_pkg::*;
#(
  parameter int REGF_DEPTH = 16
) (
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  logic          i_en,
  input  logic          i_dummy,
  input  logic          i_tx_busy,
  input  logic          i_frame_done,
  input  hdr_word_u     i_rd_data,
  output regf_rd_s      o_rd,
  output hdr_word_req_s o_req,
  output logic          o_done
);

  localparam logic [7:0] DUMMY_ADDR = 8'(REGF_DEPTH - 1);

  typedef enum logic [1:0] {IDLE, RD, LOAD, SEND} state_e;

  state_e    state;
  logic      en_q;
  logic      dummy_q;
  logic      idx;        // 0 = command word, 1 = data word
  logic      rd_en;
  logic      req_vld;
  logic      is_cmd;
  logic      last;
  hdr_word_u req_word;

  assign is_cmd = !dummy_q && !idx;
  assign last   = dummy_q || idx;

  assign o_rd  = '{en: rd_en, addr: dummy_q ? DUMMY_ADDR : {7'd0, idx}};
  assign o_req = '{vld: req_vld, preamble: is_cmd ? PRE_CMD : PRE_DATA, word: req_word};

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state   <= IDLE;
      en_q    <= 1'b0;
      dummy_q <= 1'b0;
      idx     <= 1'b0;
      rd_en   <= 1'b0;
      req_vld <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      en_q   <= i_en;
      o_done <= 1'b0;
      case (state)
        IDLE: begin
          if (i_en && !en_q) begin
            dummy_q <= i_dummy;
            idx     <= 1'b0;
            rd_en   <= 1'b1;
            state   <= RD;
          end
        end
        RD: begin
          rd_en <= 1'b0;
          state <= LOAD;   // word shows up next cycle
        end
        LOAD: begin
          if (!i_en) begin
            state <= IDLE;
          end else if (!i_tx_busy) begin
            req_vld <= 1'b1;
            state   <= SEND;
          end
        end
        SEND: begin
          req_vld <= 1'b0;
          if (i_frame_done) begin
            if (!i_en) begin
              state <= IDLE;
            end else if (last) begin
              o_done <= 1'b1;
              state  <= IDLE;
            end else begin
              idx   <= 1'b1;
              rd_en <= 1'b1;
              state <= RD;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (state == LOAD && i_en && !i_tx_busy) begin
      req_word <= i_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hdr_ddr_seq.sv ====
// normal ddr sequencer sending a command word followed by a burst of data words
`timescale 1ns/1ps
`default_nettype none

module hdr_ddr_seq
  import hdr_pkg::*;
#(
  parameter int REGF_DEPTH = 16,
  parameter int DDR_WORDS  = 4
) (
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  logic          i_en,
  input  logic          i_tx_busy,
  input  logic          i_frame_done,
  input  hdr_word_u     i_rd_data,
  output regf_rd_s      o_rd,
  output hdr_word_req_s o_req,
  output logic          o_done
);

  localparam int         CW       = $clog2(DDR_WORDS + 1);
  localparam logic [7:0] CMD_ADDR = 8'd2;   // data words follow at 3 upward

  typedef enum logic [1:0] {IDLE, RD, LOAD, SEND} state_e;

  state_e        state;
  logic          en_q;
  logic [CW-1:0] cnt;      // 0 = command word
  logic          rd_en;
  logic          req_vld;
  logic          is_cmd;
  logic          last;
  hdr_word_u     req_word;

  assign is_cmd = (cnt == '0);
  assign last   = (cnt == CW'(DDR_WORDS));

  assign o_rd  = '{en: rd_en, addr: CMD_ADDR + 8'(cnt)};
  assign o_req = '{vld: req_vld, preamble: is_cmd ? PRE_CMD : PRE_DATA, word: req_word};

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state   <= IDLE;
      en_q    <= 1'b0;
      cnt     <= '0;
      rd_en   <= 1'b0;
      req_vld <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      en_q   <= i_en;
      o_done <= 1'b0;
      case (state)
        IDLE: begin
          if (i_en && !en_q) begin
            cnt   <= '0;
            rd_en <= 1'b1;
            state <= RD;
          end
        end
        RD: begin
          rd_en <= 1'b0;
          state <= LOAD;
        end
        LOAD: begin
          if (!i_en) begin
            state <= IDLE;
          end else if (!i_tx_busy) begin
            req_vld <= 1'b1;
            state   <= SEND;
          end
        end
        SEND: begin
          req_vld <= 1'b0;
          if (i_frame_done) begin
            if (!i_en) begin
              state <= IDLE;        // aborted without done
            end else if (last) begin
              o_done <= 1'b1;
              state  <= IDLE;
            end else begin
              cnt   <= cnt + 1'b1;
              rd_en <= 1'b1;
              state <= RD;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (state == LOAD && i_en && !i_tx_busy) begin
      req_word <= i_rd_data;
    end
  end

  // burst must not reach the dummy word at the top of the register file
  a_burst_fits: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    o_rd.en |-> o_rd.addr < 8'(REGF_DEPTH - 1));

endmodule

`default_nettype wire

// ==== rtl/hdr_regf.sv ====
// word register file: host write port and a path-selected registered read port
`timescale 1ns/1ps
`default_nettype none

module hdr_regf
  import hdr_pkg::*;
#(
  parameter int REGF_DEPTH = 16
) (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst_n,
  input  logic        i_wr_en,
  input  logic [7:0]  i_wr_addr,
  input  logic [15:0] i_wr_data,
  input  hdr_path_e   i_path_sel,
  input  regf_rd_s    i_ccc_rd,
  input  regf_rd_s    i_ddr_rd,
  output hdr_word_u   o_rd_data
);

  localparam int AW = $clog2(REGF_DEPTH);

  logic [15:0] mem [REGF_DEPTH];
  regf_rd_s    rd;

  // requester picked by the engine's path select
  assign rd = (i_path_sel == PATH_CCC) ? i_ccc_rd : i_ddr_rd;

  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr[AW-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (rd.en) begin
      o_rd_data.data <= mem[rd.addr[AW-1:0]];   // one cycle read latency
    end
  end

  // host writes stay inside the configured depth
  a_wr_range: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    i_wr_en |-> i_wr_addr < 8'(REGF_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/hdr_ddr_tx.sv ====
// ddr serializer: path mux, parity generation, 20-bit frame shifter and bit counter
`timescale 1ns/1ps
`default_nettype none

module hdr_ddr_tx
  import hdr_pkg::*;
(
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  hdr_path_e     i_path_sel,
  input  hdr_word_req_s i_ccc_req,
  input  hdr_word_req_s i_ddr_req,
  output logic          o_busy,
  output logic          o_frame_done,
  output logic          o_sda_bit,
  output logic          o_sda_vld
);

  localparam logic [4:0] LAST_BIT = 5'd19;

  hdr_word_req_s req;
  logic          pa1;
  logic          pa0;
  logic          load;
  logic [19:0]   shreg;
  logic [4:0]    bit_cnt;

  assign req = (i_path_sel == PATH_CCC) ? i_ccc_req : i_ddr_req;

  // pa1 over odd payload bits, pa0 over even bits inverted
  assign pa1 = ^(req.word.data & 16'hAAAA);
  assign pa0 = ~(^(req.word.data & 16'h5555));

  assign load = req.vld && !o_sda_vld;

  assign o_busy       = o_sda_vld;
  assign o_frame_done = o_sda_vld && (bit_cnt == LAST_BIT);
  assign o_sda_bit    = shreg[19];   // msb first

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_sda_vld <= 1'b0;
      bit_cnt   <= '0;
    end else if (load) begin
      o_sda_vld <= 1'b1;
      bit_cnt   <= '0;
    end else if (o_sda_vld) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == LAST_BIT) begin
        o_sda_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (load) begin
      shreg <= {req.preamble, req.word.data, pa1, pa0};
    end else if (o_sda_vld) begin
      shreg <= {shreg[18:0], 1'b0};
    end
  end

  // sequencers hold their request until the frame in flight is out
  a_no_vld_busy: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    req.vld |-> !o_busy);

endmodule

`default_nettype wire

// ==== rtl/hdr_top.sv ====
// hdr-ddr top: engine, ccc and ddr sequencers, register file and serializer
`timescale 1ns/1ps
`default_nettype none

module hdr_top
  import hdr_pkg::*;
#(
  parameter int REGF_DEPTH = 16,
  parameter int DDR_WORDS  = 4
) (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst_n,
  input  logic        i_hdr_en,
  input  logic        i_cp,
  input  logic        i_toc,
  input  logic [2:0]  i_mode,
  input  logic        i_regf_wr_en,
  input  logic [7:0]  i_regf_wr_addr,
  input  logic [15:0] i_regf_wr_data,
  output logic        o_sda_bit,
  output logic        o_sda_vld,
  output logic        o_hdr_done,
  output hdr_path_e   o_path_sel
);

  logic          ccc_en;
  logic          ccc_dummy;
  logic          ddr_en;
  logic          ccc_done;
  logic          ddr_done;
  logic          tx_busy;
  logic          frame_done;
  regf_rd_s      ccc_rd;
  regf_rd_s      ddr_rd;
  hdr_word_u     rd_data;
  hdr_word_req_s ccc_req;
  hdr_word_req_s ddr_req;

  hdr_engine hdr_engine_inst (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst_n(i_sys_rst_n),
    .i_hdr_en   (i_hdr_en),
    .i_cp       (i_cp),
    .i_toc      (i_toc),
    .i_mode     (i_mode),
    .i_ccc_done (ccc_done),
    .i_ddr_done (ddr_done),
    .o_ccc_en   (ccc_en),
    .o_ccc_dummy(ccc_dummy),
    .o_ddr_en   (ddr_en),
    .o_path_sel (o_path_sel),
    .o_hdr_done (o_hdr_done)
  );

  hdr_ccc_seq #(.REGF_DEPTH(REGF_DEPTH)) hdr_ccc_seq_inst (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ccc_en),
    .i_dummy     (ccc_dummy),
    .i_tx_busy   (tx_busy),
    .i_frame_done(frame_done),
    .i_rd_data   (rd_data),
    .o_rd        (ccc_rd),
    .o_req       (ccc_req),
    .o_done      (ccc_done)
  );

  hdr_ddr_seq #(.REGF_DEPTH(REGF_DEPTH), .DDR_WORDS(DDR_WORDS)) hdr_ddr_seq_inst (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ddr_en),
    .i_tx_busy   (tx_busy),
    .i_frame_done(frame_done),
    .i_rd_data   (rd_data),
    .o_rd        (ddr_rd),
    .o_req       (ddr_req),
    .o_done      (ddr_done)
  );

  hdr_regf #(.REGF_DEPTH(REGF_DEPTH)) hdr_regf_inst (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst_n(i_sys_rst_n),
    .i_wr_en    (i_regf_wr_en),
    .i_wr_addr  (i_regf_wr_addr),
    .i_wr_data  (i_regf_wr_data),
    .i_path_sel (o_path_sel),
    .i_ccc_rd   (ccc_rd),
    .i_ddr_rd   (ddr_rd),
    .o_rd_data  (rd_data)
  );

  hdr_ddr_tx hdr_ddr_tx_inst (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_path_sel  (o_path_sel),
    .i_ccc_req   (ccc_req),
    .i_ddr_req   (ddr_req),
    .o_busy      (tx_busy),
    .o_frame_done(frame_done),
    .o_sda_bit   (o_sda_bit),
    .o_sda_vld   (o_sda_vld)
  );

endmodule

`default_nettype wire

// ==== tests/hdr_tb_model.svh ====
// testbench model: lfsr word source, frame parity model, value compare and frame collector
`ifndef HDR_TB_MODEL_SVH
`define HDR_TB_MODEL_SVH

// one step of a right-shifting galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) n = n ^ 32'h8020_0003;
  return n;
endfunction

// 16 lfsr bits, the first bit taken ends up as the msb
function automatic logic [15:0] next_rand_word();
  logic [15:0] w;
  int          i;
  w = '0;
  for (i = 0; i < 16; i++) begin
    w          = {w[14:0], lfsr_state[0]};
    lfsr_state = lfsr_step(lfsr_state);
  end
  return w;
endfunction

// expected frame: preamble, payload, then pa1 and pa0
function automatic logic [19:0] expect_frame(input logic [1:0] pre, input logic [15:0] w);
  logic odd_x;
  logic even_x;
  int   i;
  odd_x  = 1'b0;
  even_x = 1'b0;
  for (i = 0; i < 16; i++) begin
    if (i % 2 == 1) odd_x = odd_x ^ w[i];
    else            even_x = even_x ^ w[i];
  end
  return {pre, w, odd_x, ~even_x};  // pa0 is the inverted even xor
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// waits for the next frame and shifts in its 20 bits, msb first
task automatic collect_frame(output logic [19:0] frame, input logic apply_ctrl,
                             input logic cp_v, input logic toc_v, input logic [2:0] mode_v);
  int n;
  int b;
  n = 0;
  @(negedge sys_clk);
  while (!sda_vld) begin
    check_val("o_hdr_done", 32'(hdr_done), 32'h0);
    n++;
    if (n > FRAME_TIMEOUT) begin
      $display("timeout: no frame started within %0d cycles", FRAME_TIMEOUT);
      abort_run();
    end
    @(negedge sys_clk);
  end
  frame = {19'd0, sda_bit};
  if (apply_ctrl) drive_ctrl(cp_v, toc_v, mode_v);  // lands during bit 1
  for (b = 1; b < 20; b++) begin
    @(negedge sys_clk);
    check_val("o_sda_vld", 32'(sda_vld), 32'h1);
    check_val("o_hdr_done", 32'(hdr_done), 32'h0);
    frame = {frame[18:0], sda_bit};
  end
endtask

`endif

// ==== tests/hdr_tb.sv ====
// hdr-ddr testbench with clock, reset, dut, register preload and table-driven transfer checks
`timescale 1ns/1ps
`default_nettype none

module hdr_tb
  import hdr_pkg::*;
();

  localparam int REGF_DEPTH    = 16;
  localparam int DDR_WORDS     = 4;
  localparam int AW            = $clog2(REGF_DEPTH);
  localparam int DRV_DLY       = 2;
  localparam int FRAME_TIMEOUT = 200;
  localparam int DONE_TIMEOUT  = 50;
  localparam int QUIET_CYCLES  = 30;
  localparam int FIELDS        = 8;    // values per table line
  localparam int STIM_WORDS    = 512;

  localparam logic [7:0] SEG_DDR   = 8'h00;
  localparam logic [7:0] SEG_CCC   = 8'h01;
  localparam logic [7:0] SEG_DUMMY = 8'h02;

  logic        sys_clk;
  logic        sys_rst_n;
  logic        hdr_en;
  logic        cp;
  logic        toc;
  logic [2:0]  mode;
  logic        regf_wr_en;
  logic [7:0]  regf_wr_addr;
  logic [15:0] regf_wr_data;
  logic        sda_bit;
  logic        sda_vld;
  logic        hdr_done;
  hdr_path_e   path_sel;

  logic [31:0] lfsr_state;
  logic [15:0] regf_copy [REGF_DEPTH];   // mirror of what the host wrote
  logic [7:0]  stim [STIM_WORDS];

  hdr_top #(.REGF_DEPTH(REGF_DEPTH), .DDR_WORDS(DDR_WORDS)) hdr_top_inst (
    .i_sys_clk     (sys_clk),
    .i_sys_rst_n   (sys_rst_n),
    .i_hdr_en      (hdr_en),
    .i_cp          (cp),
    .i_toc         (toc),
    .i_mode        (mode),
    .i_regf_wr_en  (regf_wr_en),
    .i_regf_wr_addr(regf_wr_addr),
    .i_regf_wr_data(regf_wr_data),
    .o_sda_bit     (sda_bit),
    .o_sda_vld     (sda_vld),
    .o_hdr_done    (hdr_done),
    .o_path_sel    (path_sel)
  );

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic drive_ctrl(input logic cp_v, input logic toc_v, input logic [2:0] mode_v);
    @(posedge sys_clk);
    #DRV_DLY;
    cp   = cp_v;
    toc  = toc_v;
    mode = mode_v;
  endtask

  `include "hdr_tb_model.svh"

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  task automatic preload_regf();
    int a;
    for (a = 0; a < REGF_DEPTH; a++) begin
      regf_copy[a] = next_rand_word();
      @(posedge sys_clk);
      #DRV_DLY;
      regf_wr_en   = 1'b1;
      regf_wr_addr = 8'(a);
      regf_wr_data = regf_copy[a];
    end
    @(posedge sys_clk);
    #DRV_DLY;
    regf_wr_en = 1'b0;
  endtask

  // one sequencer run whose first frame carries the control inputs for the next decision
  task automatic run_segment(input logic [7:0] seg, input int nfr, input logic cp_v,
                             input logic toc_v, input logic [2:0] mode_v);
    logic [19:0]   got;
    logic [19:0]   exp;
    logic [AW-1:0] addr;
    logic [1:0]    pre;
    hdr_path_e     exp_path;
    int            f;
    exp_path = (seg == SEG_DDR) ? PATH_DDR : PATH_CCC;   // dummy word still rides the ccc path
    for (f = 0; f < nfr; f++) begin
      case (seg)
        SEG_CCC:   addr = AW'(f);
        SEG_DUMMY: addr = AW'(REGF_DEPTH - 1);
        default:   addr = AW'(2 + f);
      endcase
      pre = (f == 0 && seg != SEG_DUMMY) ? PRE_CMD : PRE_DATA;
      exp = expect_frame(pre, regf_copy[addr]);
      collect_frame(got, f == 0, cp_v, toc_v, mode_v);
      check_val($sformatf("o_sda_bit frame %0d", f), 32'(got), 32'(exp));
      check_val("o_path_sel", 32'(path_sel), 32'(exp_path));
    end
  endtask

  task automatic finish_scenario();
    int n;
    int q;
    n = 0;
    @(negedge sys_clk);
    while (!hdr_done) begin
      check_val("o_sda_vld", 32'(sda_vld), 32'h0);
      n++;
      if (n > DONE_TIMEOUT) begin
        $display("timeout: o_hdr_done never pulsed after the last frame");
        abort_run();
      end
      @(negedge sys_clk);
    end
    @(negedge sys_clk);
    check_val("o_hdr_done", 32'(hdr_done), 32'h0);   // single cycle pulse
    for (q = 0; q < QUIET_CYCLES; q++) begin           // enable held, nothing restarts after exit
      @(negedge sys_clk);
      check_val("o_sda_vld", 32'(sda_vld), 32'h0);
      check_val("o_hdr_done", 32'(hdr_done), 32'h0);
    end
    @(posedge sys_clk);
    #DRV_DLY;
    hdr_en = 1'b0;
  endtask

  initial begin
    int ln;
    int base;
    sys_rst_n    = 1'b0;
    hdr_en       = 1'b0;
    cp           = 1'b0;
    toc          = 1'b0;
    mode         = MODE_HDR_DDR;
    regf_wr_en   = 1'b0;
    regf_wr_addr = '0;
    regf_wr_data = '0;
    lfsr_state   = 32'h33f6_5c48;
    $readmemh("tests/hdr_stimulus.txt", stim);
    if ($isunknown(stim[0])) begin
      $display("the stimulus table could not be read");
      abort_run();
    end
    repeat (3) @(posedge sys_clk);
    #DRV_DLY;
    sys_rst_n = 1'b1;
    @(negedge sys_clk);
    check_val("o_sda_vld", 32'(sda_vld), 32'h0);
    check_val("o_hdr_done", 32'(hdr_done), 32'h0);
    check_val("o_path_sel", 32'(path_sel), 32'(PATH_DDR));
    ln = 0;
    while (stim[ln * FIELDS] !== 8'hff) begin
      base = ln * FIELDS;
      if ($isunknown(stim[base]) || base + FIELDS >= STIM_WORDS) begin
        $display("the stimulus table ends without its end marker");
        abort_run();
      end
      if (stim[base] == 8'h01) begin
        if (stim[base + 1] == 8'h01) preload_regf();
        @(posedge sys_clk);
        #DRV_DLY;
        cp     = (stim[base + 2] == SEG_CCC);   // start path follows the first segment
        hdr_en = 1'b1;
      end
      run_segment(stim[base + 2], int'(stim[base + 6]), stim[base + 3][0],
                  stim[base + 4][0], stim[base + 5][2:0]);
      if (stim[base + 7] == 8'h01) finish_scenario();
      ln++;
    end
    if (ln > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("no transfer was checked");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== tests/hdr_stimulus.txt ====
// one transfer segment per line, hex: start reload seg cp toc mode frames done
// seg 0 = ddr, 1 = ccc, 2 = dummy; cp toc mode are seen by the engine when the segment ends
// single ddr transfer
01 01 00 00 01 06 05 01
// single ccc transfer
01 00 01 01 01 06 02 01
// ccc restart through the dummy word into ddr
01 00 01 00 00 06 02 00
00 00 02 00 01 06 01 00
00 00 00 00 01 06 05 01
// ddr restart into ccc on fresh register data
01 01 00 01 00 06 05 00
00 00 01 01 01 06 02 01
// mode drops to 5 during a ddr transfer
01 00 00 00 00 05 05 01
// mode 5 during a ccc transfer
01 00 01 01 00 05 02 01
// ddr restart into ddr
01 00 00 00 00 06 05 00
00 00 00 00 01 06 05 01
// end marker
ff 00 00 00 00 00 00 00

// ==== project.f ====
+incdir+tests
rtl/hdr_pkg.sv
rtl/hdr_engine.sv
rtl/hdr_ccc_seq.sv
rtl/hdr_ddr_seq.sv
rtl/hdr_regf.sv
rtl/hdr_ddr_tx.sv
rtl/hdr_top.sv
tests/hdr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the hdr-ddr testbench with verilator and run it; the exit status is the verdict
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module hdr_tb -f project.f &&
  ./obj_dir/Vhdr_tb ||
  { echo "hdr_tb: build or simulation did not succeed" >&2; exit 1; }
